// File: hdl/icache_pkg.sv
package icache_pkg;

    ////////////////////////////////////////
    // geometry
    ////////////////////////////////////////
    localparam int index_width  = 4;
    localparam int offset_width = 2;
    localparam int num_ways     = 2;
    localparam int num_sets     = 1 << index_width;
    localparam int tag_width    = 32 - index_width - offset_width - 2;

    localparam int line_lsb = offset_width + 2;  // lowest index bit
    localparam int tag_lsb  = 32 - tag_width;

    typedef logic [tag_width-1:0] tag_t;
    typedef logic [(1 << offset_width)-1:0][31:0] line_t;  // word k at [k]

    ////////////////////////////////////////
    // cache operations, opcode bits 4..3
    ////////////////////////////////////////
    localparam logic [1:0] op_init    = 2'd0;
    localparam logic [1:0] op_idx_inv = 2'd1;
    localparam logic [1:0] op_hit_inv = 2'd2;
    localparam int         op_bar_bit = 31;  // barrier, invalidate all

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss_wait,
        operation,
        flush
    } ctrl_state_t;

endpackage

// File: hdl/icache_req_buf.sv
`timescale 1ns/100ps

module icache_req_buf (
    input  logic        clk,
    input  logic        rstn,
    input  logic        we,
    input  logic [31:0] in_addr,
    input  logic        in_op,
    input  logic [31:0] in_opcode,
    input  logic        in_suc,
    output logic [31:0] out_addr,
    output logic        out_op,
    output logic [31:0] out_opcode,
    output logic        out_suc
);

    // held copy of the accepted request for lookup / operation
    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_addr   <= '0;
            out_op     <= 1'b0;
            out_opcode <= '0;
            out_suc    <= 1'b0;
        end else if (we) begin
            out_addr   <= in_addr;
            out_op     <= in_op;
            out_opcode <= in_opcode;
            out_suc    <= in_suc;  // strongly ordered
        end
    end

endmodule

// File: hdl/icache_lru.sv
`timescale 1ns/100ps

module icache_lru (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [icache_pkg::index_width-1:0] index,
    input  logic                              use0,
    input  logic                              use1,
    output logic                              victim
);
    import icache_pkg::*;

    logic [num_sets-1:0] lru;  // set bit means way 1 is older

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (use0) begin
            lru[index] <= 1'b1;
        end else if (use1) begin
            lru[index] <= 1'b0;
        end
    end

    assign victim = lru[index];

endmodule

// File: hdl/icache_way_ram.sv
`timescale 1ns/100ps

module icache_way_ram #(
    parameter type entry_t = icache_pkg::tag_t
) (
    input  logic                              clk,
    input  logic                              we,
    input  logic [icache_pkg::index_width-1:0] waddr,
    input  entry_t                            wdata,
    input  logic [icache_pkg::index_width-1:0] raddr,
    output entry_t                            rdata
);
    import icache_pkg::*;

    entry_t mem [num_sets];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // async read, the lookup compares in the same cycle
    assign rdata = mem[raddr];

endmodule

// File: hdl/icache_tagv_bank.sv
`timescale 1ns/100ps

module icache_tagv_bank (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [icache_pkg::index_width-1:0] index,
    input  icache_pkg::tag_t                  tag,
    input  logic                              we,
    input  logic                              inval,
    input  logic                              init,
    input  logic                              bar,
    output logic                              hit
);
    import icache_pkg::*;

    logic [num_sets-1:0] valid;
    logic                ram_we;
    tag_t                ram_wdata;
    tag_t                stored_tag;

    // init rewrites the tag with zero
    assign ram_we    = we || init;
    assign ram_wdata = init ? '0 : tag;

    icache_way_ram #(
        .entry_t(tag_t)
    ) i_tag_ram (
        .clk  (clk),
        .we   (ram_we),
        .waddr(index),
        .wdata(ram_wdata),
        .raddr(index),
        .rdata(stored_tag)
    );

    ////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (bar) begin
            valid <= '0;                // barrier clears all sets
        end else if (init || inval) begin
            valid[index] <= 1'b0;
        end else if (we) begin
            valid[index] <= 1'b1;       // line fill
        end
    end

    assign hit = valid[index] && (stored_tag == tag);

endmodule

// File: hdl/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           req_valid,
    input  logic                           req_op,
    input  logic                           pipe_stall,
    input  logic                           pipe_flush,
    input  logic                           buf_op,
    input  logic [31:0]                    buf_opcode,
    input  logic                           buf_addr_lsb,
    input  logic                           buf_suc,
    input  logic                           hit0,
    input  logic                           hit1,
    input  logic                           victim,
    input  logic                           mem_data_ok,
    output logic                           rbuf_we,
    output logic                           rdata_valid,
    output logic                           cache_stall,
    output logic                           op_ack,
    output logic                           mem_req,
    output logic                           use0,
    output logic                           use1,
    output logic [icache_pkg::num_ways-1:0] data_we,
    output logic [icache_pkg::num_ways-1:0] inval,
    output logic                           init,
    output logic                           init_way,
    output logic                           bar,
    output logic                           choose_way,
    output logic                           choose_return
);
    import icache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        rstn_q;
    logic        miss;
    logic        accept;
    logic        valid_c;
    logic [1:0]  hit_way;  // one-hot, way 0 first

    assign miss    = !(hit0 || hit1) || buf_suc;  // suc always goes out
    assign hit_way = {hit1 && !hit0, hit0};
    assign accept  = req_valid && !pipe_stall && !cache_stall;
    assign rbuf_we = accept;
    assign op_ack  = accept && req_op;  // next state is operation

    always_ff @(posedge clk) begin
        rstn_q <= rstn;
    end

    assign rdata_valid = valid_c && rstn_q;  // nothing valid straight out of reset

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////
    always_comb begin
        next_state = idle;
        case (state)
            lookup: begin
                if (pipe_flush) begin
                    next_state = flush;
                end else if (miss) begin
                    next_state = miss_wait;
                end else if (pipe_stall) begin
                    next_state = lookup;  // hold the hit word
                end else if (accept) begin
                    next_state = req_op ? operation : lookup;
                end
            end
            miss_wait: begin
                if (!mem_data_ok) begin
                    next_state = miss_wait;
                end else if (accept) begin
                    next_state = req_op ? operation : lookup;
                end
            end
            operation, flush: begin
                if (pipe_flush) begin
                    next_state = flush;
                end else if (accept) begin
                    next_state = req_op ? operation : lookup;
                end
            end
            default: begin
                if (accept) begin
                    next_state = req_op ? operation : lookup;
                end
            end
        endcase
    end

    ////////////////////////////////////////
    // strobes
    ////////////////////////////////////////
    always_comb begin
        valid_c       = 1'b0;
        mem_req       = 1'b0;
        cache_stall   = 1'b1;
        use0          = 1'b0;
        use1          = 1'b0;
        data_we       = '0;
        inval         = '0;
        init          = 1'b0;
        init_way      = 1'b0;
        bar           = 1'b0;
        choose_way    = 1'b0;
        choose_return = 1'b0;
        case (state)
            lookup: begin
                cache_stall = miss || pipe_flush;
                choose_way  = hit_way[1];
                if (!pipe_flush) begin
                    valid_c = !miss;
                    mem_req = miss;
                    if (buf_suc) begin
                        inval = hit_way;      // drop the stale copy
                    end else begin
                        use0 = hit_way[0];
                        use1 = hit_way[1];
                    end
                end
            end
            miss_wait: begin
                mem_req     = 1'b1;
                cache_stall = !mem_data_ok;
                if (mem_data_ok) begin
                    valid_c       = 1'b1;
                    choose_return = 1'b1;     // word straight from mem_line
                    if (!buf_suc) begin
                        data_we = victim ? 2'b10 : 2'b01;
                        use0    = !victim;
                        use1    = victim;
                    end
                end
            end
            operation: begin
                cache_stall = pipe_flush;
                if (!pipe_flush && buf_op) begin
                    if (buf_opcode[op_bar_bit]) begin
                        bar = 1'b1;
                    end else begin
                        case (buf_opcode[4:3])
                            op_init: begin
                                init     = 1'b1;
                                init_way = buf_addr_lsb;
                            end
                            op_idx_inv: inval[buf_addr_lsb] = 1'b1;
                            op_hit_inv: inval = hit_way;
                            default: ;
                        endcase
                    end
                end
            end
            flush: cache_stall = pipe_flush;
            default: cache_stall = 1'b0;  // idle
        endcase
    end

endmodule

// File: hdl/icache_top.sv
`timescale 1ns/100ps

module icache_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               req_valid,
    input  logic [31:0]        req_addr,
    input  logic               req_op,
    input  logic [31:0]        req_opcode,
    input  logic               req_suc,
    input  logic               pipe_stall,
    input  logic               pipe_flush,
    output logic               rdata_valid,
    output logic [31:0]        rdata,
    output logic               cache_stall,
    output logic               op_ack,
    output logic               mem_req,
    output logic [31:0]        mem_addr,
    input  logic               mem_data_ok,
    input  icache_pkg::line_t  mem_line
);
    import icache_pkg::*;

    logic [31:0]             buf_addr;
    logic                    buf_op;
    logic [31:0]             buf_opcode;
    logic                    buf_suc;
    logic [index_width-1:0]  buf_index;
    logic [offset_width-1:0] buf_offset;
    tag_t                    buf_tag;
    logic                    rbuf_we;
    logic                    hit0;
    logic                    hit1;
    logic                    victim;
    logic                    use0;
    logic                    use1;
    logic [num_ways-1:0]     data_we;
    logic [num_ways-1:0]     inval;
    logic                    init;
    logic                    init_way;
    logic                    bar;
    logic                    choose_way;
    logic                    choose_return;
    line_t                   line0;
    line_t                   line1;
    line_t                   sel_line;

    assign buf_index  = buf_addr[tag_lsb-1:line_lsb];
    assign buf_offset = buf_addr[line_lsb-1:2];
    assign buf_tag    = buf_addr[31:tag_lsb];
    assign mem_addr   = {buf_addr[31:line_lsb], {line_lsb{1'b0}}};  // line aligned

    icache_req_buf i_rbuf (
        .clk(clk), .rstn(rstn), .we(rbuf_we),
        .in_addr(req_addr), .in_op(req_op), .in_opcode(req_opcode), .in_suc(req_suc),
        .out_addr(buf_addr), .out_op(buf_op), .out_opcode(buf_opcode), .out_suc(buf_suc)
    );

    icache_ctrl i_ctrl (
        .clk(clk), .rstn(rstn),
        .req_valid(req_valid), .req_op(req_op),
        .pipe_stall(pipe_stall), .pipe_flush(pipe_flush),
        .buf_op(buf_op), .buf_opcode(buf_opcode),
        .buf_addr_lsb(buf_addr[0]), .buf_suc(buf_suc),
        .hit0(hit0), .hit1(hit1), .victim(victim), .mem_data_ok(mem_data_ok),
        .rbuf_we(rbuf_we), .rdata_valid(rdata_valid), .cache_stall(cache_stall),
        .op_ack(op_ack), .mem_req(mem_req), .use0(use0), .use1(use1),
        .data_we(data_we), .inval(inval), .init(init), .init_way(init_way), .bar(bar),
        .choose_way(choose_way), .choose_return(choose_return)
    );

    icache_lru i_lru (
        .clk(clk), .rstn(rstn), .index(buf_index),
        .use0(use0), .use1(use1), .victim(victim)
    );

    ////////////////////////////////////////
    // ways
    ////////////////////////////////////////
    icache_tagv_bank i_tagv0 (
        .clk(clk), .rstn(rstn), .index(buf_index), .tag(buf_tag),
        .we(data_we[0]), .inval(inval[0]), .init(init && !init_way), .bar(bar),
        .hit(hit0)
    );

    icache_tagv_bank i_tagv1 (
        .clk(clk), .rstn(rstn), .index(buf_index), .tag(buf_tag),
        .we(data_we[1]), .inval(inval[1]), .init(init && init_way), .bar(bar),
        .hit(hit1)
    );

    icache_way_ram #(.entry_t(line_t)) i_line0 (
        .clk(clk), .we(data_we[0]), .waddr(buf_index), .wdata(mem_line),
        .raddr(buf_index), .rdata(line0)
    );

    icache_way_ram #(.entry_t(line_t)) i_line1 (
        .clk(clk), .we(data_we[1]), .waddr(buf_index), .wdata(mem_line),
        .raddr(buf_index), .rdata(line1)
    );

    // returning line wins over the arrays
    always_comb begin
        if (choose_return) begin
            sel_line = mem_line;
        end else if (choose_way) begin
            sel_line = line1;
        end else begin
            sel_line = line0;
        end
    end

    assign rdata = sel_line[buf_offset];

endmodule

// File: bench/icache_chk.sv
`timescale 1ns/100ps

module icache_chk (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    rdata_valid,
    input  logic                    cache_stall,
    input  logic                    op_ack,
    input  logic                    mem_req,
    input  logic [31:0]             mem_addr,
    input  logic                    mem_data_ok,
    input  icache_pkg::ctrl_state_t state
);
    import icache_pkg::*;

    int err_count = 0;

    ////////////////////////////////////////
    // memory side
    ////////////////////////////////////////
    a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_data_ok |=> mem_req)
        else begin
            err_count++;
            $error("mem_req dropped before mem_data_ok");
        end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_data_ok |=> $stable(mem_addr))
        else begin
            err_count++;
            $error("mem_addr changed while mem_req was high");
        end

    // no new request while the miss is outstanding
    a_wait_stall: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_data_ok |-> cache_stall)
        else begin
            err_count++;
            $error("cache_stall low while waiting on memory");
        end

    ////////////////////////////////////////
    // pipeline side
    ////////////////////////////////////////
    a_no_early_data: assert property (@(posedge clk) disable iff (!rstn)
        rdata_valid && mem_req |-> mem_data_ok)
        else begin
            err_count++;
            $error("rdata_valid with mem_req before mem_data_ok");
        end

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rstn) |-> state == idle && !rdata_valid && !mem_req && !op_ack)
        else begin
            err_count++;
            $error("outputs active in the first cycle after reset");
        end

endmodule

bind icache_top icache_chk i_chk (
    .clk        (clk),
    .rstn       (rstn),
    .rdata_valid(rdata_valid),
    .cache_stall(cache_stall),
    .op_ack     (op_ack),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_data_ok(mem_data_ok),
    .state      (i_ctrl.state)
);

// File: bench/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;
    import icache_pkg::*;

    localparam logic [31:0] word_pattern = 32'h5a5a_c3c3;
    localparam int          wait_limit   = 40;  // cycles per wait loop

    // lines of set 5 with different tags
    localparam logic [31:0] line_a = 32'h0000_2050;
    localparam logic [31:0] line_b = 32'h0000_3050;
    localparam logic [31:0] line_c = 32'h0000_4050;

    logic        clk;
    logic        rstn;
    logic        req_valid;
    logic [31:0] req_addr;
    logic        req_op;
    logic [31:0] req_opcode;
    logic        req_suc;
    logic        pipe_stall;
    logic        pipe_flush;
    logic        rdata_valid;
    logic [31:0] rdata;
    logic        cache_stall;
    logic        op_ack;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_data_ok;
    line_t       mem_line;

    logic        mem_req_q = 1'b0;
    int          mem_req_count = 0;
    int          op_ack_count = 0;

    icache_top i_dut (
        .clk(clk), .rstn(rstn),
        .req_valid(req_valid), .req_addr(req_addr), .req_op(req_op),
        .req_opcode(req_opcode), .req_suc(req_suc),
        .pipe_stall(pipe_stall), .pipe_flush(pipe_flush),
        .rdata_valid(rdata_valid), .rdata(rdata), .cache_stall(cache_stall),
        .op_ack(op_ack), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_data_ok(mem_data_ok), .mem_line(mem_line)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory requests and op acks seen on the ports
    always @(posedge clk) begin
        mem_req_q <= mem_req;
        if (mem_req && !mem_req_q) begin
            mem_req_count <= mem_req_count + 1;
        end
        if (op_ack) begin
            op_ack_count <= op_ack_count + 1;
        end
    end

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////
    initial begin : mem_model
        int delay;
        mem_data_ok = 1'b0;
        mem_line    = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                delay = int'($urandom % 6) + 1;
                repeat (delay) @(negedge clk);
                for (int k = 0; k < 4; k++) begin
                    mem_line[k] = (mem_addr + 32'(4 * k)) ^ word_pattern;
                end
                mem_data_ok = 1'b1;  // one cycle pulse
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

    function automatic logic [31:0] expect_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ word_pattern;
    endfunction

    function automatic logic [31:0] op_word(input logic [1:0] code);
        return {27'd0, code, 3'd0};  // code in bits 4..3
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
            else fail_now($sformatf("mismatch at %0t: %s got %h expected %h",
                                    $time, what, got, exp));
    endtask

    task automatic wait_accept();
        int   n;
        logic ok;
        n  = 0;
        ok = 1'b0;
        while (!ok) begin
            @(posedge clk);
            ok = !cache_stall && !pipe_stall;
            n++;
            if (!ok && n >= wait_limit) begin
                fail_now("timeout: request never accepted by the cache");
            end
        end
    endtask

    task automatic fetch_word(input logic [31:0] addr, input logic suc,
                              output logic [31:0] word, output int lat, output int nreq);
        int   start;
        logic got;
        start = mem_req_count;
        @(negedge clk);
        req_valid = 1'b1;
        req_op    = 1'b0;
        req_suc   = suc;
        req_addr  = addr;
        wait_accept();
        @(negedge clk);
        req_valid = 1'b0;
        req_suc   = 1'b0;
        lat = 0;
        got = 1'b0;
        word = '0;
        while (!got) begin
            @(posedge clk);
            lat++;
            got  = rdata_valid;
            word = rdata;
            if (!got && lat >= wait_limit) begin
                fail_now("timeout: no rdata_valid for a fetch");
            end
        end
        @(negedge clk);
        nreq = mem_req_count - start;
    endtask

    task automatic fetch_check(input logic [31:0] addr, input logic suc, input logic want_miss);
        logic [31:0] word;
        int          lat;
        int          nreq;
        fetch_word(addr, suc, word, lat, nreq);
        expect_eq(word, expect_word(addr), $sformatf("word at %h", addr));
        expect_eq(32'(nreq), {31'd0, want_miss}, $sformatf("memory requests for %h", addr));
        if (!want_miss) begin
            expect_eq(32'(lat), 32'd1, $sformatf("hit latency for %h", addr));
        end
    endtask

    task automatic cache_op(input logic [31:0] addr, input logic [31:0] opcode);
        int acks;
        acks = op_ack_count;
        @(negedge clk);
        req_valid  = 1'b1;
        req_op     = 1'b1;
        req_addr   = addr;
        req_opcode = opcode;
        req_suc    = 1'b0;
        wait_accept();
        @(negedge clk);
        req_valid = 1'b0;
        req_op    = 1'b0;
        @(posedge clk);  // operation cycle
        @(negedge clk);
        expect_eq(32'(op_ack_count - acks), 32'd1, "op_ack pulses for one operation");
    endtask

    // flush lands in the middle of the lookup cycle
    task automatic flush_hit(input logic [31:0] addr);
        int seen;
        seen = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req_op    = 1'b0;
        req_suc   = 1'b0;
        req_addr  = addr;
        wait_accept();
        @(negedge clk);
        req_valid  = 1'b0;
        pipe_flush = 1'b1;
        @(posedge clk);
        if (rdata_valid) seen++;
        @(negedge clk);
        pipe_flush = 1'b0;
        repeat (3) begin
            @(posedge clk);
            if (rdata_valid) seen++;
        end
        expect_eq(32'(seen), 32'd0, "rdata_valid cycles after a flushed lookup");
    endtask

    always @(negedge clk) begin
        if (i_dut.i_chk.err_count != 0) begin
            fail_now("a bound assertion on the cache ports failed");
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    initial begin : stimulus
        void'($urandom(32'h81b1));
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_op     = 1'b0;
        req_opcode = '0;
        req_suc    = 1'b0;
        pipe_stall = 1'b0;
        pipe_flush = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        fetch_check(32'h0000_1024, 1'b0, 1'b1);  // cold miss
        fetch_check(32'h0000_1028, 1'b0, 1'b0);  // same line

        // lru in set 5, C evicts B
        fetch_check(line_a, 1'b0, 1'b1);
        fetch_check(line_b, 1'b0, 1'b1);
        fetch_check(line_a + 32'd4, 1'b0, 1'b0);
        fetch_check(line_c, 1'b0, 1'b1);
        fetch_check(line_a + 32'd8, 1'b0, 1'b0);
        fetch_check(line_b + 32'd12, 1'b0, 1'b1);

        // strongly ordered goes out and drops the cached copy
        fetch_check(32'h0000_1024, 1'b1, 1'b1);
        fetch_check(32'h0000_1020, 1'b0, 1'b1);

        cache_op(line_a, op_word(op_hit_inv));
        fetch_check(line_a, 1'b0, 1'b1);
        fetch_check(32'h0000_1020, 1'b0, 1'b0);

        // set 5, way 1 holds B
        cache_op(32'h0000_0051, op_word(op_idx_inv));
        fetch_check(line_a + 32'd4, 1'b0, 1'b0);
        fetch_check(line_b, 1'b0, 1'b1);

        cache_op(32'h0000_0000, 32'd1 << op_bar_bit);
        fetch_check(32'h0000_1024, 1'b0, 1'b1);
        fetch_check(line_a, 1'b0, 1'b1);

        flush_hit(32'h0000_1024);
        fetch_check(32'h0000_1028, 1'b0, 1'b0);

        repeat (2) @(negedge clk);
        if (i_dut.i_chk.err_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            fail_now("a bound assertion on the cache ports failed");
        end
    end

endmodule

// File: vlog.f
hdl/icache_pkg.sv
hdl/icache_req_buf.sv
hdl/icache_lru.sv
hdl/icache_way_ram.sv
hdl/icache_tagv_bank.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
bench/icache_chk.sv
bench/icache_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module icache_tb -o icache_sim || exit 1
out=$(./obj_dir/icache_sim +verilator+error+limit+100)
echo "$out"
grep -qx "All checks passed" <<< "$out" && echo "PASS" || { echo "FAIL"; exit 1; }
